// File: Makefile
# Verilator build and run for the inter_read testbench

TOP ?= tb_inter_read
SEED ?= 0
LOG ?= sim.log
FILELIST ?= filelist.f
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
hdl/inter_read_pkg.sv
hdl/mv_select.sv
hdl/fetch_window.sv
hdl/preload_sequencer.sv
hdl/ref_addr_clip.sv
hdl/inter_read.sv
test/tb_inter_read.sv

// File: hdl/fetch_window.sv
`default_nettype none

module fetch_window (
	input wire logic is_luma,
	input wire logic is_chroma,
	input wire logic big_block,
	input wire inter_read_pkg::mv_t mv_x,
	input wire inter_read_pkg::mv_t mv_y,
	input wire logic [3:0] off_x,
	input wire logic [3:0] off_y,
	input wire inter_read_pkg::mb_pos_t mb_x,
	input wire inter_read_pkg::mb_pos_t mb_y,
	output inter_read_pkg::frac_t frac_x,
	output inter_read_pkg::frac_t frac_y,
	output logic chroma_copy,
	output inter_read_pkg::word_t word_first,
	output inter_read_pkg::word_t word_last,
	output inter_read_pkg::coord_t row_first,
	output inter_read_pkg::coord_t row_last
);
	import inter_read_pkg::*;

	coord_t mb_size;
	coord_t blk_size;
	coord_t org_x;
	coord_t org_y;
	coord_t before_x;
	coord_t before_y;
	coord_t after_x;
	coord_t after_y;
	coord_t col_first;
	coord_t col_last;

	assign mb_size = is_luma ? coord_t'(luma_mb_size) : coord_t'(chroma_mb_size);
	assign blk_size = big_block ? coord_t'(8) : coord_t'(4);

	// integer part of the vector, floor for negatives
	assign org_x = coord_t'(mb_x) * mb_size + coord_t'(off_x)
		+ (is_luma ? coord_t'(mv_x >>> 2) : coord_t'(mv_x >>> 3));
	assign org_y = coord_t'(mb_y) * mb_size + coord_t'(off_y)
		+ (is_luma ? coord_t'(mv_y >>> 2) : coord_t'(mv_y >>> 3));

	assign frac_x = is_luma ? {1'b0, mv_x[1:0]} : (is_chroma ? mv_x[2:0] : 3'd0);
	assign frac_y = is_luma ? {1'b0, mv_y[1:0]} : (is_chroma ? mv_y[2:0] : 3'd0);

	assign chroma_copy = is_chroma && frac_x == 3'd0 && frac_y == 3'd0;

	always_comb begin
		before_x = '0;
		before_y = '0;
		after_x = '0;
		after_y = '0;
		if (is_luma) begin
			// each axis widens on its own fraction
			if (frac_x != 3'd0) begin
				before_x = coord_t'(luma_taps_before);
				after_x = coord_t'(luma_taps_after);
			end
			if (frac_y != 3'd0) begin
				before_y = coord_t'(luma_taps_before);
				after_y = coord_t'(luma_taps_after);
			end
		end else if (frac_x != 3'd0 || frac_y != 3'd0) begin
			after_x = coord_t'(chroma_taps_after);	// 5x5 for bilinear
			after_y = coord_t'(chroma_taps_after);
		end
	end

	assign col_first = org_x - before_x;
	assign col_last = org_x + blk_size - coord_t'(1) + after_x;

	assign word_first = word_t'(col_first >>> word_shift);
	assign word_last = word_t'(col_last >>> word_shift);

	assign row_first = org_y - before_y;
	assign row_last = org_y + blk_size - coord_t'(1) + after_y;

endmodule

`default_nettype wire

// File: hdl/inter_read.sv
`default_nettype none

module inter_read (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic trigger,
	input wire logic data_valid,
	input wire logic mb_is_inter,
	input wire logic mv_is16x16,
	input wire logic [3:0] mv_below8x8,
	input wire inter_read_pkg::blk_num_t blk_num,
	input wire inter_read_pkg::mv_t mvx [16],
	input wire inter_read_pkg::mv_t mvy [16],
	input wire inter_read_pkg::mb_pos_t mb_x,
	input wire inter_read_pkg::mb_pos_t mb_y,
	input wire inter_read_pkg::mb_pos_t pic_width_mbs_minus1,
	input wire inter_read_pkg::mb_pos_t pic_height_mbs_minus1,
	output logic luma_rd,
	output logic chroma_rd,
	output logic read_end,
	output logic chroma_copy,
	output inter_read_pkg::luma_addr_t luma_addr,
	output inter_read_pkg::chroma_addr_t chroma_addr,
	output inter_read_pkg::frac_t pos_frac_x,
	output inter_read_pkg::frac_t pos_frac_y
);
	import inter_read_pkg::*;

	logic is_luma;
	logic is_chroma;
	logic big_block;
	logic skip;
	logic is_cr;
	mv_t mv_x;
	mv_t mv_y;
	logic [3:0] off_x;
	logic [3:0] off_y;
	word_t word_first;
	word_t word_last;
	word_t cur_word;
	coord_t row_first;
	coord_t row_last;
	coord_t cur_row;

	assign is_cr = blk_num >= cr_first;

	mv_select u_mv_select (
		.blk_num(blk_num),
		.mb_is_inter(mb_is_inter),
		.mv_is16x16(mv_is16x16),
		.mv_below8x8(mv_below8x8),
		.mvx(mvx),
		.mvy(mvy),
		.is_luma(is_luma),
		.is_chroma(is_chroma),
		.big_block(big_block),
		.skip(skip),
		.mv_x(mv_x),
		.mv_y(mv_y),
		.off_x(off_x),
		.off_y(off_y)
	);

	fetch_window u_fetch_window (
		.is_luma(is_luma),
		.is_chroma(is_chroma),
		.big_block(big_block),
		.mv_x(mv_x),
		.mv_y(mv_y),
		.off_x(off_x),
		.off_y(off_y),
		.mb_x(mb_x),
		.mb_y(mb_y),
		.frac_x(pos_frac_x),
		.frac_y(pos_frac_y),
		.chroma_copy(chroma_copy),
		.word_first(word_first),
		.word_last(word_last),
		.row_first(row_first),
		.row_last(row_last)
	);

	preload_sequencer u_preload_sequencer (
		.clk(clk),
		.reset_n(reset_n),
		.trigger(trigger),
		.data_valid(data_valid),
		.is_luma(is_luma),
		.is_chroma(is_chroma),
		.skip(skip),
		.word_first(word_first),
		.word_last(word_last),
		.row_first(row_first),
		.row_last(row_last),
		.luma_rd(luma_rd),
		.chroma_rd(chroma_rd),
		.read_end(read_end),
		.cur_word(cur_word),
		.cur_row(cur_row)
	);

	ref_addr_clip u_ref_addr_clip (
		.cur_word(cur_word),
		.cur_row(cur_row),
		.is_luma(is_luma),
		.is_cr(is_cr),
		.pic_width_mbs_minus1(pic_width_mbs_minus1),
		.pic_height_mbs_minus1(pic_height_mbs_minus1),
		.luma_addr(luma_addr),
		.chroma_addr(chroma_addr)
	);

endmodule

`default_nettype wire

// File: hdl/inter_read_pkg.sv
`default_nettype none

package inter_read_pkg;

	// motion vector component, quarter-pel luma / eighth-pel chroma
	typedef logic signed [10:0] mv_t;

	// pixel coordinate before clipping
	typedef logic signed [11:0] coord_t;

	// 4-pixel word column
	typedef logic signed [9:0] word_t;

	// 0-15 luma, 18-21 cb, 22-25 cr
	typedef logic [4:0] blk_num_t;

	typedef logic [6:0] mb_pos_t;

	// word column [19:11], row [10:0]
	typedef logic [19:0] luma_addr_t;

	// cr flag [18], word column [17:10], row [9:0]
	typedef logic [18:0] chroma_addr_t;

	typedef logic [2:0] frac_t;

	localparam blk_num_t cb_first = 5'd18;
	localparam blk_num_t cr_first = 5'd22;

	localparam int luma_mb_size = 16;
	localparam int chroma_mb_size = 8;

	localparam int word_pixels = 4;
	localparam int word_shift = $clog2(word_pixels);

	// six-tap filter reach
	localparam int luma_taps_before = 2;
	localparam int luma_taps_after = 3;

	localparam int chroma_taps_after = 1;	// bilinear

endpackage

`default_nettype wire

// File: hdl/mv_select.sv
`default_nettype none

module mv_select (
	input wire inter_read_pkg::blk_num_t blk_num,
	input wire logic mb_is_inter,
	input wire logic mv_is16x16,
	input wire logic [3:0] mv_below8x8,
	input wire inter_read_pkg::mv_t mvx [16],
	input wire inter_read_pkg::mv_t mvy [16],
	output logic is_luma,
	output logic is_chroma,
	output logic big_block,
	output logic skip,
	output inter_read_pkg::mv_t mv_x,
	output inter_read_pkg::mv_t mv_y,
	output logic [3:0] off_x,
	output logic [3:0] off_y
);
	import inter_read_pkg::*;

	blk_num_t chroma_rel;
	logic [1:0] quad;
	logic below;
	logic [3:0] mv_idx;

	assign chroma_rel = blk_num - cb_first;

	assign is_luma = mb_is_inter && !blk_num[4];
	assign is_chroma = mb_is_inter && blk_num >= cb_first && blk_num <= cr_first + 5'd3;

	// cb and cr share the quadrant numbering
	assign quad = is_luma ? blk_num[3:2] : chroma_rel[1:0];

	assign below = mv_below8x8[quad] && !mv_is16x16;

	// one 8x8 fetch per quadrant, the other three blocks reuse it
	assign big_block = is_luma && !below;
	assign skip = big_block && blk_num[1:0] != 2'b00;

	always_comb begin
		if (mv_is16x16)
			mv_idx = 4'd0;
		else if (is_luma && below)
			mv_idx = blk_num[3:0];		// own sub-block vector
		else
			mv_idx = {quad, 2'b00};		// first vector of quadrant
	end

	always_comb begin
		if (is_luma || is_chroma) begin
			mv_x = mvx[mv_idx];
			mv_y = mvy[mv_idx];
		end else begin
			mv_x = '0;
			mv_y = '0;
		end
	end

	always_comb begin
		off_x = 4'd0;
		off_y = 4'd0;
		if (is_luma) begin
			off_x = {blk_num[2], blk_num[0] & below, 2'b00};
			off_y = {blk_num[3], blk_num[1] & below, 2'b00};
		end else if (is_chroma) begin
			off_x = {1'b0, quad[0], 2'b00};	// 8x8 chroma mb, 4x4 per quadrant
			off_y = {1'b0, quad[1], 2'b00};
		end
	end

endmodule

`default_nettype wire

// File: hdl/preload_sequencer.sv
`default_nettype none

module preload_sequencer (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic trigger,
	input wire logic data_valid,
	input wire logic is_luma,
	input wire logic is_chroma,
	input wire logic skip,
	input wire inter_read_pkg::word_t word_first,
	input wire inter_read_pkg::word_t word_last,
	input wire inter_read_pkg::coord_t row_first,
	input wire inter_read_pkg::coord_t row_last,
	output logic luma_rd,
	output logic chroma_rd,
	output logic read_end,
	output inter_read_pkg::word_t cur_word,
	output inter_read_pkg::coord_t cur_row
);
	import inter_read_pkg::*;

	logic busy;
	logic luma_blk;
	word_t word_start;
	word_t word_end;
	coord_t row_end;
	logic start;
	logic skip_hit;
	logic accept;
	logic row_done;
	logic blk_done;

	// triggers during a block are dropped
	assign start = trigger && !busy && (is_chroma || (is_luma && !skip));
	assign skip_hit = trigger && !busy && is_luma && skip;

	assign accept = busy && data_valid;
	assign row_done = cur_word == word_end;
	assign blk_done = row_done && cur_row == row_end;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy <= 1'b0;
			luma_blk <= 1'b0;
			cur_word <= '0;
			cur_row <= '0;
		end else if (start) begin
			busy <= 1'b1;
			luma_blk <= is_luma;
			cur_word <= word_first;
			cur_row <= row_first;
		end else if (accept) begin
			if (blk_done) begin
				busy <= 1'b0;				// position holds on last word
			end else if (row_done) begin
				cur_word <= word_start;
				cur_row <= cur_row + coord_t'(1);
			end else begin
				cur_word <= cur_word + word_t'(1);
			end
		end
	end

	// window limits of the block in flight
	always_ff @(posedge clk) begin
		if (start) begin
			word_start <= word_first;
			word_end <= word_last;
			row_end <= row_last;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			read_end <= 1'b0;
		else
			read_end <= skip_hit || (accept && blk_done);
	end

	assign luma_rd = busy && luma_blk;
	assign chroma_rd = busy && !luma_blk;

endmodule

`default_nettype wire

// File: hdl/ref_addr_clip.sv
`default_nettype none

module ref_addr_clip (
	input wire inter_read_pkg::word_t cur_word,
	input wire inter_read_pkg::coord_t cur_row,
	input wire logic is_luma,
	input wire logic is_cr,
	input wire inter_read_pkg::mb_pos_t pic_width_mbs_minus1,
	input wire inter_read_pkg::mb_pos_t pic_height_mbs_minus1,
	output inter_read_pkg::luma_addr_t luma_addr,
	output inter_read_pkg::chroma_addr_t chroma_addr
);
	import inter_read_pkg::*;

	logic [12:0] width_mbs;
	logic [12:0] height_mbs;
	logic [12:0] mb_size;
	logic signed [12:0] pic_w;
	logic signed [12:0] pic_h;
	logic signed [12:0] x_max;
	logic signed [12:0] y_max;
	logic signed [12:0] x_pix;
	logic signed [12:0] y_pix;
	logic signed [12:0] x_clip;
	logic signed [12:0] y_clip;
	logic signed [12:0] x_word;

	assign width_mbs = 13'(pic_width_mbs_minus1) + 13'd1;
	assign height_mbs = 13'(pic_height_mbs_minus1) + 13'd1;

	// chroma plane is half size in both directions
	assign mb_size = is_luma ? 13'(luma_mb_size) : 13'(chroma_mb_size);
	assign pic_w = width_mbs * mb_size;
	assign pic_h = height_mbs * mb_size;

	assign x_max = pic_w - 13'(word_pixels);	// last whole word
	assign y_max = pic_h - 13'sd1;

	assign x_pix = 13'(cur_word) <<< word_shift;
	assign y_pix = 13'(cur_row);

	always_comb begin
		if (x_pix < 0)
			x_clip = '0;
		else if (x_pix > x_max)
			x_clip = x_max;
		else
			x_clip = x_pix;

		if (y_pix < 0)
			y_clip = '0;
		else if (y_pix > y_max)
			y_clip = y_max;
		else
			y_clip = y_pix;
	end

	assign x_word = x_clip >>> word_shift;

	assign luma_addr = is_luma ? {x_word[8:0], y_clip[10:0]} : '0;
	assign chroma_addr = is_luma ? '0 : {is_cr, x_word[7:0], y_clip[9:0]};

endmodule

`default_nettype wire

// File: test/inter_read_patterns.txt
# blk is16x16 below8x8(hex) mb_x mb_y width_m1 height_m1 mvx mvy backpressure
# read_count first_addr(hex) last_addr(hex)
0 1 0 2 3 10 8 0 0 0 16 04030 04837
4 0 0 2 3 10 8 5 -6 1 52 0482c 06038
8 0 0 0 0 10 8 -40 -40 0 24 00000 00005
12 0 0 10 8 10 8 63 61 1 52 1588f 1588f
0 1 0 5 4 10 8 -9 3 1 52 0903e 0a84a
5 0 0 2 3 10 8 0 0 0 0 00000 00000
3 1 0 2 3 10 8 0 0 1 0 00000 00000
7 0 2 2 3 10 8 7 -3 0 27 05031 06039
2 0 1 2 3 10 8 8 4 1 8 04035 04838
13 0 8 2 3 10 8 -1 2 0 27 05036 0603e
18 1 0 2 3 10 8 0 0 0 4 01018 0101b
21 0 8 2 3 10 8 13 -5 1 10 0141b 0181f
18 1 0 0 0 10 8 -20 -20 0 10 00000 00001
23 0 0 2 3 10 8 8 16 0 8 4141a 4181d
25 0 0 10 8 10 8 40 40 1 8 45447 45447

// File: test/tb_inter_read.sv
`default_nettype none

module tb_inter_read;
	timeunit 1ns;
	timeprecision 1ps;

	import inter_read_pkg::*;

	logic clk;
	logic reset_n;
	logic trigger;
	logic data_valid;
	logic mb_is_inter;
	logic mv_is16x16;
	logic [3:0] mv_below8x8;
	blk_num_t blk_num;
	mv_t mvx [16];
	mv_t mvy [16];
	mb_pos_t mb_x;
	mb_pos_t mb_y;
	mb_pos_t pic_width_mbs_minus1;
	mb_pos_t pic_height_mbs_minus1;
	logic luma_rd;
	logic chroma_rd;
	logic read_end;
	logic chroma_copy;
	luma_addr_t luma_addr;
	chroma_addr_t chroma_addr;
	frac_t pos_frac_x;
	frac_t pos_frac_y;

	int value_errors;
	int other_errors;
	logic [19:0] exp_q [$];	// expected addresses in row-major order
	logic m_luma;
	logic m_skip;
	logic m_copy;
	frac_t m_frac_x;
	frac_t m_frac_y;
	int m_idx;

	inter_read DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_luma_addr(input string name, input luma_addr_t exp, input luma_addr_t act);
		if (act !== exp) begin
			value_errors++;
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_chroma_addr(input string name, input chroma_addr_t exp,
		input chroma_addr_t act);
		if (act !== exp) begin
			value_errors++;
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_frac(input string name, input frac_t exp, input frac_t act);
		if (act !== exp) begin
			value_errors++;
			$display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			value_errors++;
			$display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input logic [19:0] exp, input logic [19:0] act);
		if (m_luma)
			check_luma_addr({"luma_addr ", name}, luma_addr_t'(exp), luma_addr_t'(act));
		else
			check_chroma_addr({"chroma_addr ", name}, chroma_addr_t'(exp), chroma_addr_t'(act));
	endtask

	// vector choice, window and clipped address list for one block
	task automatic build_model(input int blk, input int is16, input int below8, input int bx,
		input int by, input int wm1, input int hm1, input int vx, input int vy);
		int q;
		int below;
		int s;
		int msz;
		int org_x;
		int org_y;
		int fx;
		int fy;
		int c0;
		int c1;
		int r0;
		int r1;
		int x;
		int y;
		int r;
		int w;
		m_luma = blk < 16;
		q = m_luma ? (blk >> 2) & 3 : (blk - 18) % 4;
		below = (is16 == 0 && ((below8 >> q) & 1) != 0) ? 1 : 0;
		if (is16 != 0)
			m_idx = 0;
		else if (m_luma && below != 0)
			m_idx = blk;
		else
			m_idx = 4 * q;
		s = (m_luma && below == 0) ? 8 : 4;
		m_skip = m_luma && below == 0 && (blk & 3) != 0;
		if (m_luma) begin
			msz = 16;
			org_x = bx * 16 + 8 * ((blk >> 2) & 1) + 4 * below * (blk & 1) + (vx >>> 2);
			org_y = by * 16 + 8 * ((blk >> 3) & 1) + 4 * below * ((blk >> 1) & 1) + (vy >>> 2);
			fx = vx & 3;
			fy = vy & 3;
			c0 = fx != 0 ? org_x - 2 : org_x;
			c1 = fx != 0 ? org_x + s + 2 : org_x + s - 1;
			r0 = fy != 0 ? org_y - 2 : org_y;
			r1 = fy != 0 ? org_y + s + 2 : org_y + s - 1;
		end else begin
			msz = 8;
			org_x = bx * 8 + 4 * (q & 1) + (vx >>> 3);
			org_y = by * 8 + 4 * (q >> 1) + (vy >>> 3);
			fx = vx & 7;
			fy = vy & 7;
			c0 = org_x;
			r0 = org_y;
			c1 = (fx != 0 || fy != 0) ? org_x + 4 : org_x + 3;
			r1 = (fx != 0 || fy != 0) ? org_y + 4 : org_y + 3;
		end
		m_frac_x = frac_t'(fx);
		m_frac_y = frac_t'(fy);
		m_copy = !m_luma && fx == 0 && fy == 0;
		exp_q.delete();
		if (!m_skip) begin
			for (r = r0; r <= r1; r++) begin
				for (w = c0 >>> 2; w <= c1 >>> 2; w++) begin
					x = 4 * w;
					x = x < 0 ? 0 : (x > (wm1 + 1) * msz - 4 ? (wm1 + 1) * msz - 4 : x);
					y = r < 0 ? 0 : (r > (hm1 + 1) * msz - 1 ? (hm1 + 1) * msz - 1 : r);
					if (m_luma)
						exp_q.push_back(20'((x / 4) * 2048 + y));
					else
						exp_q.push_back(20'((blk >= 22 ? 262144 : 0) + (x / 4) * 1024 + y));
				end
			end
		end
	endtask

	task automatic run_block(input int line_no, input int bp, input int exp_count,
		input logic [19:0] exp_first, input logic [19:0] exp_last);
		int n;
		int cycles;
		logic done;
		logic prev_last;
		logic stalled;
		logic rd;
		logic [19:0] cur_a;
		logic [19:0] held_a;
		logic [19:0] first_a;
		logic [19:0] last_a;
		n = 0;
		cycles = 0;
		done = 1'b0;
		prev_last = 1'b0;
		stalled = 1'b0;
		held_a = '0;
		first_a = '0;
		last_a = '0;
		@(posedge clk);	// DUT takes the trigger here
		trigger <= 1'b0;
		check_frac("pos_frac_x", m_frac_x, pos_frac_x);
		check_frac("pos_frac_y", m_frac_y, pos_frac_y);
		check_flag("chroma_copy", m_copy, chroma_copy);
		while (!done && cycles < 400) begin
			@(posedge clk);
			cycles++;
			rd = luma_rd || chroma_rd;
			cur_a = m_luma ? luma_addr : {1'b0, chroma_addr};
			if (cycles == 1)
				check_flag("rd", !m_skip, rd);
			check_flag("read_end", prev_last || (m_skip && cycles == 1), read_end);
			if (stalled) begin	// back-pressure holds the request
				check_flag("rd held", 1'b1, rd);
				check_addr("held", held_a, cur_a);
			end
			stalled = rd && !data_valid;
			held_a = cur_a;
			done = read_end;
			prev_last = 1'b0;
			if (rd && data_valid) begin
				check_flag("luma_rd", m_luma, luma_rd);
				check_flag("chroma_rd", !m_luma, chroma_rd);
				if (m_luma)
					check_chroma_addr("chroma_addr unused", '0, chroma_addr);
				else
					check_luma_addr("luma_addr unused", '0, luma_addr);
				if (n < exp_q.size()) begin
					check_addr("read", exp_q[n], cur_a);
				end else begin
					other_errors++;
					$display("block on line %0d read more words than its window holds", line_no);
				end
				if (n == 0)
					first_a = cur_a;
				last_a = cur_a;
				n++;
				prev_last = n == exp_q.size();
			end
			data_valid <= bp != 0 ? ($urandom % 4 != 0) : 1'b1;
		end
		if (!done) begin
			other_errors++;
			$display("timeout: block on line %0d never raised read_end", line_no);
		end
		check_count("model read count", exp_count, exp_q.size());
		check_count("read count", exp_count, n);
		if (n > 0) begin
			check_addr("first", exp_first, first_a);
			check_addr("last", exp_last, last_a);
		end
	endtask

	initial begin
		int fd;
		int line_no;
		int i;
		string line;
		int blk;
		int is16;
		int below8;
		int bx;
		int by;
		int wm1;
		int hm1;
		int vx;
		int vy;
		int bp;
		int cnt;
		logic [19:0] first_a;
		logic [19:0] last_a;
		void'($urandom(32'h8369579c));
		value_errors = 0;
		other_errors = 0;
		reset_n = 1'b0;
		trigger = 1'b0;
		data_valid = 1'b0;
		mb_is_inter = 1'b1;
		mv_is16x16 = 1'b0;
		mv_below8x8 = '0;
		blk_num = '0;
		for (i = 0; i < 16; i++) begin
			mvx[i] = '0;
			mvy[i] = '0;
		end
		mb_x = '0;
		mb_y = '0;
		pic_width_mbs_minus1 = '0;
		pic_height_mbs_minus1 = '0;
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		check_flag("luma_rd", 1'b0, luma_rd);
		check_flag("chroma_rd", 1'b0, chroma_rd);
		check_flag("read_end", 1'b0, read_end);
		check_luma_addr("luma_addr", '0, luma_addr);
		check_chroma_addr("chroma_addr", '0, chroma_addr);
		fd = $fopen("test/inter_read_patterns.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open test/inter_read_patterns.txt");
		end else begin
			line_no = 0;
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				line_no++;
				if (line.len() > 0 && line[0] != "#" && $sscanf(line,
					"%d %d %h %d %d %d %d %d %d %d %d %h %h", blk, is16, below8, bx, by,
					wm1, hm1, vx, vy, bp, cnt, first_a, last_a) == 13) begin
					build_model(blk, is16, below8, bx, by, wm1, hm1, vx, vy);
					@(posedge clk);
					for (i = 0; i < 16; i++) begin
						mvx[i] <= mv_t'($urandom);	// wrong pick shows up as a wrong window
						mvy[i] <= mv_t'($urandom);
					end
					mvx[m_idx] <= mv_t'(vx);
					mvy[m_idx] <= mv_t'(vy);
					blk_num <= blk_num_t'(blk);
					mv_is16x16 <= is16 != 0;
					mv_below8x8 <= 4'(below8);
					mb_x <= mb_pos_t'(bx);
					mb_y <= mb_pos_t'(by);
					pic_width_mbs_minus1 <= mb_pos_t'(wm1);
					pic_height_mbs_minus1 <= mb_pos_t'(hm1);
					data_valid <= bp != 0 ? ($urandom % 4 != 0) : 1'b1;
					trigger <= 1'b1;
					run_block(line_no, bp, cnt, first_a, last_a);
				end
			end
			$fclose(fd);
		end
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
